// ==== include/mem_cfg.svh ====
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Region bounds, the high bound of each region is exclusive
`define MEM_REGION_CART_LO  17'h0_0000
`define MEM_REGION_CART_HI  17'h0_8000
`define MEM_REGION_VRAM_LO  17'h0_8000
`define MEM_REGION_VRAM_HI  17'h0_A000
`define MEM_REGION_WRAM_LO  17'h0_C000
`define MEM_REGION_WRAM_HI  17'h0_E000
`define MEM_REGION_OAM_LO   17'h0_FE00
`define MEM_REGION_OAM_HI   17'h0_FEA0
`define MEM_REGION_IOREG_LO 17'h0_FF00
`define MEM_REGION_IOREG_HI 17'h0_FF80
`define MEM_REGION_HRAM_LO  17'h0_FF80
`define MEM_REGION_HRAM_HI  17'h0_FFFF

// Address widths of the on-chip memories
`define VRAM_AW  13
`define WRAM_AW  13
`define OAM_AW   8
`define HRAM_AW  7
`define IOREG_AW 7

`define DMA_REG_ADDR  16'hFF46
`define DMA_LEN       160
`define UNMAPPED_DATA 8'hFF   // What the CPU sees outside every region

`endif

// ==== source/mem_pkg.sv ====
package mem_pkg;

   // Region a master address decodes to
   typedef enum logic [2:0] {
      REG_NONE,
      REG_CART,
      REG_VRAM,
      REG_WRAM,
      REG_OAM,
      REG_IOREG,
      REG_HRAM
   } mem_region_e;

   // OAM DMA engine states
   typedef enum logic [1:0] {
      DMA_IDLE,
      DMA_RUN,     // Issuing one source read per cycle
      DMA_DRAIN    // Last reads returning, last writes going out
   } dma_state_e;

   // Single-cycle request strobe, there is no back-pressure
   typedef struct packed {
      logic        valid;
      logic        we;
      logic [15:0] addr;
      logic [7:0]  wdata;
   } mem_req_t;

   // Read data returned one cycle after an accepted read
   typedef struct packed {
      logic       valid;
      logic [7:0] rdata;
   } mem_rsp_t;

   // Error pulses raised by the router
   typedef struct packed {
      logic same_port;       // A master lost a region to a higher priority one
      logic ppu_boundary;
      logic rdma_boundary;
      logic wdma_boundary;
   } mem_err_t;

endpackage

// ==== source/sync_ram.sv ====
`timescale 1ns/1ps

module sync_ram import mem_pkg::*; #(
   parameter int ADDR_W = 8
) (
   input  logic       clk,
   input  logic       rst_n,
   input  mem_req_t   req,
   output logic [7:0] rdata
);

   logic [7:0]        mem [2**ADDR_W];
   logic [ADDR_W-1:0] idx;

   // The router passes the full address, only the low bits select a byte
   assign idx = req.addr[ADDR_W-1:0];

   always_ff @(posedge clk) begin
      if (req.valid && req.we) begin
         mem[idx] <= req.wdata;
      end
   end

   // Read data is registered and held until the next read
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rdata <= '0;
      end else if (req.valid && !req.we) begin
         rdata <= mem[idx];
      end
   end

endmodule

// ==== source/io_regs.sv ====
`timescale 1ns/1ps

`include "mem_cfg.svh"

module io_regs import mem_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  mem_req_t   req,
   output logic [7:0] rdata,
   output logic       dma_start,
   output logic [7:0] dma_page
);

   logic [7:0]           regs [2**`IOREG_AW];
   logic [`IOREG_AW-1:0] idx;
   logic                 hit_dma;
   logic                 dma_wr;

   assign idx     = req.addr[`IOREG_AW-1:0];
   assign hit_dma = (req.addr == `DMA_REG_ADDR);
   assign dma_wr  = req.valid && req.we && hit_dma;

   // The DMA register lives outside the general file
   always_ff @(posedge clk) begin
      if (req.valid && req.we && !hit_dma) begin
         regs[idx] <= req.wdata;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rdata     <= '0;
         dma_start <= 1'b0;
         dma_page  <= '0;
      end else begin
         dma_start <= dma_wr;   // Start pulse lands one cycle after the write
         if (dma_wr) begin
            dma_page <= req.wdata;
         end
         if (req.valid && !req.we) begin
            rdata <= hit_dma ? dma_page : regs[idx];
         end
      end
   end

endmodule

// ==== source/oam_dma.sv ====
`timescale 1ns/1ps

`include "mem_cfg.svh"

module oam_dma import mem_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       start,
   input  logic [7:0] page,
   output mem_req_t   rd_req,
   input  mem_rsp_t   rd_rsp,
   output mem_req_t   wr_req,
   output logic       active
);

   localparam logic [7:0] LAST_IDX = 8'(`DMA_LEN - 1);

   dma_state_e state;
   logic [7:0] page_q;
   logic [7:0] idx;        // Source index of the read issued this cycle
   logic       rd_pend_q;  // A read went out last cycle
   logic [7:0] rsp_idx_q;  // Index of the read whose data arrives now
   logic       wr_valid_q;
   logic [7:0] wr_idx_q;
   logic [7:0] wr_data_q;

   // Source reads walk the page, one per cycle
   assign rd_req.valid = (state == DMA_RUN);
   assign rd_req.we    = 1'b0;
   assign rd_req.addr  = {page_q, 8'h00} + 16'(idx);
   assign rd_req.wdata = '0;

   assign wr_req.valid = wr_valid_q;
   assign wr_req.we    = 1'b1;
   assign wr_req.addr  = 16'(`MEM_REGION_OAM_LO) + 16'(wr_idx_q);
   assign wr_req.wdata = wr_data_q;

   assign active = (state != DMA_IDLE);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= DMA_IDLE;
         page_q     <= '0;
         idx        <= '0;
         rd_pend_q  <= 1'b0;
         rsp_idx_q  <= '0;
         wr_valid_q <= 1'b0;
         wr_idx_q   <= '0;
         wr_data_q  <= '0;
      end else begin
         rd_pend_q  <= rd_req.valid;
         rsp_idx_q  <= idx;
         wr_valid_q <= rd_pend_q && rd_rsp.valid;  // A dropped read writes nothing
         wr_idx_q   <= rsp_idx_q;
         wr_data_q  <= rd_rsp.rdata;
         case (state)
            DMA_IDLE: begin
               if (start) begin   // A start during a transfer never reaches here
                  state  <= DMA_RUN;
                  page_q <= page;
                  idx    <= '0;
               end
            end
            DMA_RUN: begin
               if (idx == LAST_IDX) begin
                  state <= DMA_DRAIN;
               end else begin
                  idx <= idx + 8'd1;
               end
            end
            DMA_DRAIN: begin
               // No read outstanding, so the write on the bus now is the last one
               if (!rd_pend_q) begin
                  state <= DMA_IDLE;
               end
            end
            default: state <= DMA_IDLE;
         endcase
      end
   end

endmodule

// ==== source/mem_router.sv ====
`timescale 1ns/1ps

`include "mem_cfg.svh"

module mem_router import mem_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  mem_req_t   cpu_req,
   input  mem_req_t   ppu_req,
   input  mem_req_t   rdma_req,
   input  mem_req_t   wdma_req,
   output mem_rsp_t   cpu_rsp,
   output mem_rsp_t   ppu_rsp,
   output mem_rsp_t   rdma_rsp,
   output mem_req_t   cart_req,
   output mem_req_t   vram_req,
   output mem_req_t   wram_req,
   output mem_req_t   oam_req,
   output mem_req_t   ioreg_req,
   output mem_req_t   hram_req,
   input  logic [7:0] cart_rdata,
   input  logic [7:0] vram_rdata,
   input  logic [7:0] wram_rdata,
   input  logic [7:0] oam_rdata,
   input  logic [7:0] ioreg_rdata,
   input  logic [7:0] hram_rdata,
   output mem_err_t   err
);

   // Masters are numbered in priority order, lowest number wins
   localparam int NM     = 4;
   localparam int M_WDMA = 0;
   localparam int M_RDMA = 1;
   localparam int M_CPU  = 2;
   localparam int M_PPU  = 3;

   mem_req_t      m_req [NM];
   mem_region_e   m_reg [NM];
   mem_region_e   rsel_q [NM];   // Region that served each master's last read
   logic [NM-1:0] m_valid;
   logic [NM-1:0] m_ok;          // Region is legal for this master
   logic [NM-1:0] m_go;
   logic [NM-1:0] grant;
   logic [NM-1:0] rd_acc;
   logic [NM-1:0] rd_q;
   mem_req_t      s_req [7];     // Indexed by region
   logic [7:0]    s_rdata [7];
   mem_err_t      err_d;

   function automatic logic in_range(input logic [15:0] a, input logic [16:0] lo,
                                     input logic [16:0] hi);
      return ({1'b0, a} >= lo) && ({1'b0, a} < hi);
   endfunction

   function automatic mem_region_e decode(input logic [15:0] a);
      mem_region_e r;
      r = REG_NONE;   // Echo RAM, the gap and the top byte stay unmapped
      if (in_range(a, `MEM_REGION_CART_LO, `MEM_REGION_CART_HI))   r = REG_CART;
      if (in_range(a, `MEM_REGION_VRAM_LO, `MEM_REGION_VRAM_HI))   r = REG_VRAM;
      if (in_range(a, `MEM_REGION_WRAM_LO, `MEM_REGION_WRAM_HI))   r = REG_WRAM;
      if (in_range(a, `MEM_REGION_OAM_LO, `MEM_REGION_OAM_HI))     r = REG_OAM;
      if (in_range(a, `MEM_REGION_IOREG_LO, `MEM_REGION_IOREG_HI)) r = REG_IOREG;
      if (in_range(a, `MEM_REGION_HRAM_LO, `MEM_REGION_HRAM_HI))   r = REG_HRAM;
      return r;
   endfunction

   assign m_req[M_WDMA] = wdma_req;
   assign m_req[M_RDMA] = rdma_req;
   assign m_req[M_CPU]  = cpu_req;
   assign m_req[M_PPU]  = ppu_req;

   always_comb begin
      for (int m = 0; m < NM; m++) begin
         m_reg[m]   = decode(m_req[m].addr);
         m_valid[m] = m_req[m].valid;
      end
      // Boundary rules, the CPU may go anywhere that is mapped
      m_ok[M_CPU]  = (m_reg[M_CPU] != REG_NONE);
      m_ok[M_PPU]  = (m_reg[M_PPU] inside {REG_VRAM, REG_OAM});
      m_ok[M_RDMA] = !m_req[M_RDMA].we && (m_reg[M_RDMA] inside {REG_CART, REG_VRAM, REG_WRAM});
      m_ok[M_WDMA] = m_req[M_WDMA].we && (m_reg[M_WDMA] == REG_OAM);
      m_go = m_valid & m_ok;
   end

   // Walk masters by priority, each takes its region if still free
   always_comb begin
      s_req = '{default: '0};
      grant = '0;
      for (int m = 0; m < NM; m++) begin
         if (m_go[m] && !s_req[m_reg[m]].valid) begin
            s_req[m_reg[m]] = m_req[m];
            grant[m]        = 1'b1;
         end
      end
   end

   always_comb begin
      for (int m = 0; m < NM; m++) begin
         rd_acc[m] = grant[m] && !m_req[m].we;
      end
      // Unmapped CPU reads still answer, the data mux supplies the fill byte
      if (cpu_req.valid && !cpu_req.we && (m_reg[M_CPU] == REG_NONE)) begin
         rd_acc[M_CPU] = 1'b1;
      end
      err_d.same_port     = |(m_go & ~grant);
      err_d.ppu_boundary  = m_valid[M_PPU] && !m_ok[M_PPU];
      err_d.rdma_boundary = m_valid[M_RDMA] && !m_ok[M_RDMA];
      err_d.wdma_boundary = m_valid[M_WDMA] && !m_ok[M_WDMA];
   end

   assign cart_req  = s_req[REG_CART];
   assign vram_req  = s_req[REG_VRAM];
   assign wram_req  = s_req[REG_WRAM];
   assign oam_req   = s_req[REG_OAM];
   assign ioreg_req = s_req[REG_IOREG];
   assign hram_req  = s_req[REG_HRAM];

   assign s_rdata[REG_NONE]  = `UNMAPPED_DATA;
   assign s_rdata[REG_CART]  = cart_rdata;
   assign s_rdata[REG_VRAM]  = vram_rdata;
   assign s_rdata[REG_WRAM]  = wram_rdata;
   assign s_rdata[REG_OAM]   = oam_rdata;
   assign s_rdata[REG_IOREG] = ioreg_rdata;
   assign s_rdata[REG_HRAM]  = hram_rdata;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_q <= '0;
         err  <= '0;
         for (int m = 0; m < NM; m++) begin
            rsel_q[m] <= REG_NONE;
         end
      end else begin
         rd_q <= rd_acc;
         err  <= err_d;   // Flags pulse in the cycle after the offending request
         for (int m = 0; m < NM; m++) begin
            rsel_q[m] <= m_reg[m];
         end
      end
   end

   // Slave data is steered back by the region registered with the read
   assign cpu_rsp.valid  = rd_q[M_CPU];
   assign cpu_rsp.rdata  = s_rdata[rsel_q[M_CPU]];
   assign ppu_rsp.valid  = rd_q[M_PPU];
   assign ppu_rsp.rdata  = s_rdata[rsel_q[M_PPU]];
   assign rdma_rsp.valid = rd_q[M_RDMA];
   assign rdma_rsp.rdata = s_rdata[rsel_q[M_RDMA]];

endmodule

// ==== source/mem_subsystem.sv ====
`timescale 1ns/1ps

`include "mem_cfg.svh"

module mem_subsystem import mem_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  mem_req_t   cpu_req,
   input  mem_req_t   ppu_req,
   output mem_rsp_t   cpu_rsp,
   output mem_rsp_t   ppu_rsp,
   output mem_req_t   cart_req,
   input  logic [7:0] cart_rdata,
   output mem_err_t   err,
   output logic       dma_active
);

   mem_req_t   rdma_req, wdma_req;
   mem_rsp_t   rdma_rsp;
   mem_req_t   vram_req, wram_req, oam_req, ioreg_req, hram_req;
   logic [7:0] vram_rdata, wram_rdata, oam_rdata, ioreg_rdata, hram_rdata;
   logic       dma_start;
   logic [7:0] dma_page;

   mem_router u_router (
      .clk, .rst_n,
      .cpu_req, .ppu_req, .rdma_req, .wdma_req,
      .cpu_rsp, .ppu_rsp, .rdma_rsp,
      .cart_req, .vram_req, .wram_req, .oam_req, .ioreg_req, .hram_req,
      .cart_rdata, .vram_rdata, .wram_rdata, .oam_rdata, .ioreg_rdata, .hram_rdata,
      .err
   );

   sync_ram #(.ADDR_W(`VRAM_AW)) vram_ram (
      .clk, .rst_n, .req(vram_req), .rdata(vram_rdata)
   );

   sync_ram #(.ADDR_W(`WRAM_AW)) wram_ram (
      .clk, .rst_n, .req(wram_req), .rdata(wram_rdata)
   );

   sync_ram #(.ADDR_W(`OAM_AW)) oam_ram (
      .clk, .rst_n, .req(oam_req), .rdata(oam_rdata)
   );

   sync_ram #(.ADDR_W(`HRAM_AW)) hram_ram (
      .clk, .rst_n, .req(hram_req), .rdata(hram_rdata)
   );

   io_regs u_io_regs (
      .clk, .rst_n, .req(ioreg_req), .rdata(ioreg_rdata),
      .dma_start, .dma_page
   );

   oam_dma u_oam_dma (
      .clk, .rst_n,
      .start(dma_start), .page(dma_page),
      .rd_req(rdma_req), .rd_rsp(rdma_rsp),
      .wr_req(wdma_req), .active(dma_active)
   );

endmodule

// ==== sim/mem_subsystem_properties.sv ====
`timescale 1ns/1ps

module mem_subsystem_properties import mem_pkg::*; (
   input logic        clk,
   input logic        rst_n,
   input mem_req_t    cpu_req,
   input mem_req_t    ppu_req,
   input mem_req_t    rdma_req,
   input mem_rsp_t    cpu_rsp,
   input mem_rsp_t    ppu_rsp,
   input mem_rsp_t    rdma_rsp,
   input mem_err_t    err,
   input logic [3:0]  grant,
   input mem_region_e m_reg [4]
);

   int assert_fails = 0;   // Read by the testbench at the end of the run

   // One bit per master that holds this region in the current cycle
   for (genvar r = 1; r < 7; r++) begin : g_region
      logic [3:0] owners;
      always_comb begin
         for (int m = 0; m < 4; m++) begin
            owners[m] = grant[m] && (m_reg[m] == mem_region_e'(r));
         end
      end
      a_one_owner: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(owners))
         else begin
            assert_fails++;
            $error("Region %0d was granted to more than one master", r);
         end
   end

   a_err_reset: assert property (@(posedge clk) !rst_n |-> (err == '0))
      else begin
         assert_fails++;
         $error("Error flags not low while reset is asserted");
      end

   // A response needs a read strobe from the same master one cycle earlier
   a_cpu_rsp: assert property (@(posedge clk) disable iff (!rst_n)
      cpu_rsp.valid |-> $past(cpu_req.valid && !cpu_req.we))
      else begin
         assert_fails++;
         $error("CPU response without a read in the previous cycle");
      end

   a_ppu_rsp: assert property (@(posedge clk) disable iff (!rst_n)
      ppu_rsp.valid |-> $past(ppu_req.valid && !ppu_req.we))
      else begin
         assert_fails++;
         $error("PPU response without a read in the previous cycle");
      end

   a_rdma_rsp: assert property (@(posedge clk) disable iff (!rst_n)
      rdma_rsp.valid |-> $past(rdma_req.valid && !rdma_req.we))
      else begin
         assert_fails++;
         $error("DMA read response without a read in the previous cycle");
      end

endmodule

bind mem_router mem_subsystem_properties u_props (
   .clk, .rst_n, .cpu_req, .ppu_req, .rdma_req,
   .cpu_rsp, .ppu_rsp, .rdma_rsp, .err, .grant, .m_reg
);

// ==== sim/tb_mem_subsystem.sv ====
`timescale 1ns/1ps

`include "mem_cfg.svh"

module tb_mem_subsystem import mem_pkg::*; ();

   localparam logic [15:0] SCRATCH_IO = 16'hFF10;
   localparam logic [15:0] OAM_BASE   = 16'(`MEM_REGION_OAM_LO);
   localparam logic [7:0]  SRC_PAGE   = 8'hC1;   // DMA source page in work RAM
   localparam mem_req_t    IDLE       = '0;
   localparam mem_rsp_t    NO_RSP     = '0;
   localparam mem_err_t    NO_ERR     = 4'b0000;
   localparam mem_err_t    SAME_PORT  = 4'b1000;
   localparam mem_err_t    PPU_BOUND  = 4'b0100;

   logic        clk;
   logic        rst_n;
   mem_req_t    cpu_req, ppu_req, cart_req;
   mem_rsp_t    cpu_rsp, ppu_rsp;
   logic [7:0]  cart_rdata;
   mem_err_t    err;
   logic        dma_active;
   logic [7:0]  sb [65536];   // Expected byte at every address written so far
   logic [31:0] rng;

   // Step table with one entry per cycle of stimulus
   mem_req_t q_cpu [$];
   mem_req_t q_ppu [$];
   mem_rsp_t q_exp_cpu [$];
   mem_rsp_t q_exp_ppu [$];
   mem_err_t q_exp_err [$];
   string    q_name [$];

   mem_subsystem uut (
      .clk, .rst_n, .cpu_req, .ppu_req, .cpu_rsp, .ppu_rsp,
      .cart_req, .cart_rdata, .err, .dma_active
   );

   always #50 clk = ~clk;

   // Cartridge ROM model answers a read in the next cycle
   always @(posedge clk) begin
      if (cart_req.valid && !cart_req.we) begin
         cart_rdata <= cart_req.addr[7:0] ^ cart_req.addr[15:8];
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic mem_req_t read_req(input logic [15:0] a);
      return '{valid: 1'b1, we: 1'b0, addr: a, wdata: 8'h00};
   endfunction

   function automatic mem_req_t write_req(input logic [15:0] a, input logic [7:0] d);
      return '{valid: 1'b1, we: 1'b1, addr: a, wdata: d};
   endfunction

   function automatic mem_rsp_t read_rsp(input logic [7:0] d);
      return '{valid: 1'b1, rdata: d};
   endfunction

   // Only a CPU request inside the cartridge window reaches the cartridge bus
   function automatic mem_req_t expected_cart_req(input mem_req_t c);
      if (c.valid && ({1'b0, c.addr} < `MEM_REGION_CART_HI)) begin
         return c;
      end
      return IDLE;
   endfunction

   task automatic stop_with_failure();
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_rsp(input string n, input mem_rsp_t exp, input mem_rsp_t act);
      if (act.valid !== exp.valid || (exp.valid && act.rdata !== exp.rdata)) begin
         $display("ERR %s expected %h actual %h", n, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic check_err(input string n, input mem_err_t exp, input mem_err_t act);
      if (act !== exp) begin
         $display("ERR %s expected %b actual %b", n, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic check_req(input string n, input mem_req_t exp, input mem_req_t act);
      if (act !== exp) begin
         $display("ERR %s expected %h actual %h", n, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic add_step(input mem_req_t c, input mem_req_t p, input mem_rsp_t ec,
                           input mem_rsp_t ep, input mem_err_t ee, input string n);
      q_cpu.push_back(c);
      q_ppu.push_back(p);
      q_exp_cpu.push_back(ec);
      q_exp_ppu.push_back(ep);
      q_exp_err.push_back(ee);
      q_name.push_back(n);
   endtask

   // CPU write of a fresh random byte, then the read that must return it
   task automatic cpu_write_read(input logic [15:0] a, input string n);
      logic [7:0] d;
      rng = xorshift32(rng);
      d = rng[15:8];
      sb[a] = d;
      add_step(write_req(a, d), IDLE, NO_RSP, NO_RSP, NO_ERR, {n, " write"});
      add_step(read_req(a), IDLE, read_rsp(d), NO_RSP, NO_ERR, {n, " read"});
   endtask

   // Starts on a falling edge; each step's results are checked one cycle later
   task automatic run_steps();
      for (int i = 0; i < q_name.size(); i++) begin
         cpu_req = q_cpu[i];
         ppu_req = q_ppu[i];
         @(negedge clk);
         check_req({q_name[i], " cart_req"}, expected_cart_req(q_cpu[i]), cart_req);
         check_rsp({q_name[i], " cpu_rsp"}, q_exp_cpu[i], cpu_rsp);
         check_rsp({q_name[i], " ppu_rsp"}, q_exp_ppu[i], ppu_rsp);
         check_err({q_name[i], " err"}, q_exp_err[i], err);
      end
      cpu_req = IDLE;
      ppu_req = IDLE;
      q_cpu.delete();
      q_ppu.delete();
      q_exp_cpu.delete();
      q_exp_ppu.delete();
      q_exp_err.delete();
      q_name.delete();
   endtask

   task automatic wait_dma_done();
      int n;
      n = 0;
      while (!dma_active) begin
         if (n == 8) begin
            $display("DMA did not start within 8 cycles of the trigger write");
            stop_with_failure();
         end
         @(negedge clk);
         n++;
      end
      // The start pulse lags the trigger write by a cycle and dma_active lags it by one more
      if (n != 1) begin
         $display("ERR dma_active rise expected %0d actual %0d", 1, n);
         stop_with_failure();
      end
      n = 0;
      while (dma_active) begin
         if (n > `DMA_LEN + 8) begin
            $display("DMA still active after %0d cycles", n);
            stop_with_failure();
         end
         check_err("dma transfer", NO_ERR, err);
         @(negedge clk);
         n++;
      end
      if (n != `DMA_LEN + 2) begin
         $display("ERR dma_active cycles expected %0d actual %0d", `DMA_LEN + 2, n);
         stop_with_failure();
      end
   endtask

   initial begin
      logic [15:0] wa, va, oa, ha, a;
      logic [15:0] holes [6];
      clk        = 1'b0;
      rst_n      = 1'b0;
      cpu_req    = IDLE;
      ppu_req    = IDLE;
      cart_rdata = '0;
      rng        = 32'h6be8;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      for (int k = 0; k < 3; k++) begin
         rng = xorshift32(rng);
         wa  = 16'hC000 + 16'(rng[12:0]);
         va  = 16'h8000 + 16'(rng[28:16]);
         oa  = OAM_BASE + 16'(rng[7:0] % 160);
         ha  = 16'hFF80 + 16'(rng[23:16] % 127);
         cpu_write_read(wa, "wram");
         cpu_write_read(va, "vram");
         cpu_write_read(oa, "oam");
         cpu_write_read(ha, "hram");
      end
      cpu_write_read(SCRATCH_IO, "io scratch");

      for (int k = 0; k < 4; k++) begin
         rng = xorshift32(rng);
         a   = 16'(rng[14:0]);
         add_step(read_req(a), IDLE, read_rsp(a[7:0] ^ a[15:8]), NO_RSP, NO_ERR, "cart read");
      end
      add_step(read_req(16'h7FFF), IDLE, read_rsp(8'h80), NO_RSP, NO_ERR, "cart top read");
      add_step(write_req(16'h2000, 8'hA5), IDLE, NO_RSP, NO_RSP, NO_ERR, "cart write");
      holes = '{16'hA000, 16'hBFFF, 16'hE000, 16'hFEA0, 16'hFEFF, 16'hFFFF};
      foreach (holes[h]) begin
         add_step(read_req(holes[h]), IDLE, read_rsp(`UNMAPPED_DATA), NO_RSP, NO_ERR,
                  "unmapped read");
      end
      add_step(write_req(16'hA000, 8'h5A), IDLE, NO_RSP, NO_RSP, NO_ERR, "unmapped write");

      // A dropped PPU write must leave work RAM untouched
      add_step(IDLE, read_req(va), NO_RSP, read_rsp(sb[va]), NO_ERR, "ppu vram read");
      add_step(IDLE, read_req(oa), NO_RSP, read_rsp(sb[oa]), NO_ERR, "ppu oam read");
      add_step(IDLE, read_req(wa), NO_RSP, NO_RSP, PPU_BOUND, "ppu wram read");
      add_step(IDLE, write_req(wa, ~sb[wa]), NO_RSP, NO_RSP, PPU_BOUND, "ppu wram write");
      add_step(read_req(wa), read_req(va), read_rsp(sb[wa]), read_rsp(sb[va]), NO_ERR,
               "cpu wram with ppu vram");
      add_step(read_req(oa), read_req(oa), read_rsp(sb[oa]), NO_RSP, SAME_PORT,
               "cpu ppu oam conflict");

      for (int i = 0; i < `DMA_LEN; i++) begin
         rng = xorshift32(rng);
         a   = {SRC_PAGE, 8'h00} + 16'(i);
         sb[a] = rng[7:0];
         add_step(write_req(a, rng[7:0]), IDLE, NO_RSP, NO_RSP, NO_ERR, "dma source fill");
      end
      add_step(write_req(`DMA_REG_ADDR, SRC_PAGE), IDLE, NO_RSP, NO_RSP, NO_ERR,
               "dma trigger");
      run_steps();
      wait_dma_done();

      // OAM now holds a copy of the source page
      for (int i = 0; i < `DMA_LEN; i++) begin
         a = OAM_BASE + 16'(i);
         sb[a] = sb[{SRC_PAGE, 8'h00} + 16'(i)];
         add_step(read_req(a), IDLE, read_rsp(sb[a]), NO_RSP, NO_ERR, "oam after dma");
      end
      add_step(read_req(`DMA_REG_ADDR), IDLE, read_rsp(SRC_PAGE), NO_RSP, NO_ERR,
               "dma register read");
      run_steps();

      if (uut.u_router.u_props.assert_fails != 0) begin
         $display("Router assertions failed %0d times", uut.u_router.u_props.assert_fails);
         stop_with_failure();
      end else begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule

// ==== src.f ====
+incdir+include
source/mem_pkg.sv
source/sync_ram.sv
source/io_regs.sv
source/oam_dma.sv
source/mem_router.sv
source/mem_subsystem.sv
sim/mem_subsystem_properties.sv
sim/tb_mem_subsystem.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/mem_pkg.sv
      - source/sync_ram.sv
      - source/io_regs.sv
      - source/oam_dma.sv
      - source/mem_router.sv
      - source/mem_subsystem.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/mem_subsystem_properties.sv
      - sim/tb_mem_subsystem.sv
